/* hw/exc_macros.svh */
`ifndef EXC_MACROS_SVH
`define EXC_MACROS_SVH

// Exception vector bases and offsets.
`define EXC_BOOT_BASE   32'hBFC0_0200
`define EXC_OFF_GENERAL 32'h0000_0180
`define EXC_OFF_INT     32'h0000_0200

// Reset values.
`define EBASE_RESET     32'h8000_0000
`define STATUS_RESET    32'h0040_0000 // BEV only.

// Status bit positions.
`define STATUS_IE       0
`define STATUS_EXL      1
`define STATUS_UM       4
`define STATUS_IM_S     8
`define STATUS_IM_E     15
`define STATUS_BEV      22

// Cause bit positions.
`define CAUSE_EXC_S     2
`define CAUSE_IP_S      8
`define CAUSE_IV        23
`define CAUSE_BD        31

`endif

/* hw/exc_pkg.sv */
package exc_pkg;

    // MIPS exception codes as written to Cause ExcCode.
    typedef enum logic [4:0] {
        EXC_INT  = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_CPU  = 5'd11,
        EXC_OV   = 5'd12,
        EXC_TR   = 5'd13
    } exc_code_t;

    typedef enum logic [2:0] {
        CHK_NONE,
        CHK_SYSCALL,
        CHK_BREAK,
        CHK_TRAP,
        CHK_OVERFLOW,
        CHK_RESERVED,
        CHK_ERET
    } exc_chk_t;

    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LOAD_WORD,
        MEM_LOAD_HALF,
        MEM_LOAD_BYTE,
        MEM_STORE_WORD,
        MEM_STORE_HALF,
        MEM_STORE_BYTE
    } mem_mode_t;

    // Register numbers on the coprocessor-0 port.
    typedef enum logic [4:0] {
        CP0_BADVADDR = 5'd8,
        CP0_STATUS   = 5'd12,
        CP0_CAUSE    = 5'd13,
        CP0_EPC      = 5'd14,
        CP0_EBASE    = 5'd15
    } cp0_reg_t;

endpackage

/* hw/address_error_checker.sv */
`timescale 1ns/1ns

module address_error_checker (
    input  logic [31:0]       pc,
    input  logic [31:0]       mem_addr,
    input  exc_pkg::mem_mode_t mem_mode,
    input  logic              kernel_mode,
    output logic              fetch_error,
    output logic              load_error,
    output logic              store_error
);

    import exc_pkg::*;

    logic is_load;
    logic is_store;
    logic misaligned;
    logic seg_error;

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        misaligned = 1'b0;
        case (mem_mode)
            MEM_LOAD_WORD: begin
                is_load    = 1'b1;
                misaligned = |mem_addr[1:0];
            end
            MEM_LOAD_HALF: begin
                is_load    = 1'b1;
                misaligned = mem_addr[0];
            end
            MEM_LOAD_BYTE: is_load = 1'b1; // Bytes are always aligned.
            MEM_STORE_WORD: begin
                is_store   = 1'b1;
                misaligned = |mem_addr[1:0];
            end
            MEM_STORE_HALF: begin
                is_store   = 1'b1;
                misaligned = mem_addr[0];
            end
            MEM_STORE_BYTE: is_store = 1'b1;
            default: ;
        endcase
    end

    // Upper half of the address space is kernel only.
    assign seg_error = mem_addr[31] & ~kernel_mode;

    assign fetch_error = (|pc[1:0]) | (pc[31] & ~kernel_mode);
    assign load_error  = is_load & (misaligned | seg_error);
    assign store_error = is_store & (misaligned | seg_error);

endmodule

/* hw/exception_classifier.sv */
`timescale 1ns/1ns
`include "exc_macros.svh"

module exception_classifier (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [31:0]         pc,
    input  logic [31:0]         mem_addr,
    input  exc_pkg::mem_mode_t  mem_mode,
    input  exc_pkg::exc_chk_t   exc_chk,
    input  logic                cond_flag,
    input  logic                is_cop0,
    input  logic                is_branch,
    input  logic [5:0]          hardware_int,
    input  logic [31:0]         status,
    input  logic [1:0]          cause_ip_soft,
    input  logic                s2_ready,
    output logic                s1_valid,
    output logic                s1_exc_taken,
    output logic                s1_eret,
    output exc_pkg::exc_code_t  s1_code,
    output logic [31:0]         s1_epc,
    output logic                s1_in_bd,
    output logic [31:0]         s1_badvaddr,
    output logic                s1_load_badvaddr,
    output logic [31:0]         s1_next_pc
);

    import exc_pkg::*;

    logic        kernel_mode;
    logic        int_pending;
    logic        fetch_error;
    logic        load_error;
    logic        store_error;
    logic        exc_now;
    logic        eret_now;
    exc_code_t   code_now;
    logic [31:0] badvaddr_now;
    logic        load_bv_now;
    logic        prev_branch; // Last accepted instruction was a branch.
    logic        accept;

    assign kernel_mode = status[`STATUS_EXL] | ~status[`STATUS_UM];

    // Level-sensitive; EXL blocks nesting.
    assign int_pending = (|({hardware_int, cause_ip_soft} & status[`STATUS_IM_E:`STATUS_IM_S]))
                         & status[`STATUS_IE] & ~status[`STATUS_EXL];

    address_error_checker address_error_checker_inst (
        .pc          (pc),
        .mem_addr    (mem_addr),
        .mem_mode    (mem_mode),
        .kernel_mode (kernel_mode),
        .fetch_error (fetch_error),
        .load_error  (load_error),
        .store_error (store_error)
    );

    // Fixed priority, highest first.
    always_comb begin
        exc_now      = 1'b1;
        code_now     = EXC_INT;
        badvaddr_now = pc;
        load_bv_now  = 1'b0;
        if (int_pending) begin
            code_now = EXC_INT;
        end else if (fetch_error) begin
            code_now    = EXC_ADEL;
            load_bv_now = 1'b1;
        end else if (is_cop0 && !kernel_mode) begin
            code_now = EXC_CPU;
        end else if (exc_chk == CHK_RESERVED) begin
            code_now = EXC_RI;
        end else if (exc_chk == CHK_SYSCALL) begin
            code_now = EXC_SYS;
        end else if (exc_chk == CHK_BREAK) begin
            code_now = EXC_BP;
        end else if (exc_chk == CHK_OVERFLOW && cond_flag) begin
            code_now = EXC_OV;
        end else if (exc_chk == CHK_TRAP && cond_flag) begin
            code_now = EXC_TR;
        end else if (load_error || store_error) begin
            code_now     = load_error ? EXC_ADEL : EXC_ADES;
            badvaddr_now = mem_addr;
            load_bv_now  = 1'b1;
        end else begin
            exc_now = 1'b0;
        end
    end

    assign eret_now = ~exc_now & (exc_chk == CHK_ERET);

    // Hold off younger instructions until Status is committed.
    assign in_ready = ~(s1_valid & (s1_exc_taken | s1_eret)) & (~s1_valid | s2_ready);
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid    <= 1'b0;
            prev_branch <= 1'b0;
        end else begin
            if (accept) begin
                s1_valid    <= 1'b1;
                prev_branch <= is_branch & ~(exc_now | eret_now);
            end else if (s2_ready) begin
                s1_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            s1_exc_taken     <= exc_now;
            s1_eret          <= eret_now;
            s1_code          <= code_now;
            s1_epc           <= prev_branch ? pc - 32'd4 : pc; // Delay slot.
            s1_in_bd         <= prev_branch;
            s1_badvaddr      <= badvaddr_now;
            s1_load_badvaddr <= load_bv_now;
            s1_next_pc       <= pc + 32'd4;
        end
    end

endmodule

/* hw/cop0_exc_regs.sv */
`timescale 1ns/1ns
`include "exc_macros.svh"

module cop0_exc_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                s1_valid,
    output logic                s2_ready,
    input  logic                s1_exc_taken,
    input  logic                s1_eret,
    input  exc_pkg::exc_code_t  s1_code,
    input  logic [31:0]         s1_epc,
    input  logic                s1_in_bd,
    input  logic [31:0]         s1_badvaddr,
    input  logic                s1_load_badvaddr,
    input  logic [31:0]         s1_next_pc,
    input  logic                out_ready,
    input  logic                cp0_we,
    input  exc_pkg::cp0_reg_t   cp0_sel,
    input  logic [31:0]         cp0_wdata,
    output logic [31:0]         status,
    output logic [1:0]          cause_ip_soft,
    output logic [31:0]         cp0_rdata,
    output logic                out_valid,
    output logic                redirect,
    output logic                exc_taken,
    output exc_pkg::exc_code_t  exc_code,
    output logic [31:0]         target
);

    import exc_pkg::*;

    exc_code_t   cause_exc;
    logic        cause_iv;
    logic        cause_bd;
    logic [31:0] cause;
    logic [31:0] epc;
    logic [31:0] badvaddr;
    logic [31:0] ebase;
    logic [31:0] vector;
    logic [31:0] target_next;
    logic        move;

    assign s2_ready = ~out_valid | out_ready;
    assign move     = s1_valid & s2_ready;

    always_comb begin
        cause = '0;
        cause[`CAUSE_BD] = cause_bd;
        cause[`CAUSE_IV] = cause_iv;
        cause[`CAUSE_IP_S +: 2] = cause_ip_soft;
        cause[`CAUSE_EXC_S +: 5] = cause_exc;
    end

    // Separate interrupt vector only with IV set.
    assign vector = (status[`STATUS_BEV] ? `EXC_BOOT_BASE : ebase)
                  + ((s1_code == EXC_INT && cause_iv) ? `EXC_OFF_INT : `EXC_OFF_GENERAL);
    assign target_next = s1_exc_taken ? vector : (s1_eret ? epc : s1_next_pc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status        <= `STATUS_RESET;
            cause_ip_soft <= 2'b00;
            cause_iv      <= 1'b0;
            cause_bd      <= 1'b0;
            cause_exc     <= EXC_INT;
            epc           <= '0;
            ebase         <= `EBASE_RESET;
        end else begin
            if (cp0_we) begin
                case (cp0_sel)
                    CP0_STATUS: status <= cp0_wdata;
                    CP0_CAUSE: begin
                        cause_ip_soft <= cp0_wdata[`CAUSE_IP_S +: 2];
                        cause_iv      <= cp0_wdata[`CAUSE_IV];
                    end
                    CP0_EPC:   epc <= cp0_wdata;
                    CP0_EBASE: ebase <= {cp0_wdata[31:12], 12'h000}; // 4 KiB aligned.
                    default: ;
                endcase
            end
            if (move && s1_exc_taken) begin
                status[`STATUS_EXL] <= 1'b1;
                cause_exc <= s1_code;
                cause_bd  <= s1_in_bd;
                epc       <= s1_epc;
            end else if (move && s1_eret) begin
                status[`STATUS_EXL] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cp0_we && cp0_sel == CP0_BADVADDR) begin
            badvaddr <= cp0_wdata;
        end
        if (move && s1_exc_taken && s1_load_badvaddr) begin
            badvaddr <= s1_badvaddr;
        end
    end

    always_comb begin
        case (cp0_sel)
            CP0_BADVADDR: cp0_rdata = badvaddr;
            CP0_STATUS:   cp0_rdata = status;
            CP0_CAUSE:    cp0_rdata = cause;
            CP0_EPC:      cp0_rdata = epc;
            CP0_EBASE:    cp0_rdata = ebase;
            default:      cp0_rdata = '0;
        endcase
    end

    // Output register, held under back-pressure.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            redirect  <= 1'b0;
        end else if (move) begin
            out_valid <= 1'b1;
            redirect  <= s1_exc_taken | s1_eret;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            exc_taken <= s1_exc_taken;
            exc_code  <= s1_code;
            target    <= target_next;
        end
    end

endmodule

/* hw/exception_unit.sv */
`timescale 1ns/1ns

module exception_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [31:0]         pc,
    input  logic [31:0]         mem_addr,
    input  exc_pkg::mem_mode_t  mem_mode,
    input  exc_pkg::exc_chk_t   exc_chk,
    input  logic                cond_flag,
    input  logic                is_cop0,
    input  logic                is_branch,
    input  logic [5:0]          hardware_int,
    output logic                out_valid,
    input  logic                out_ready,
    output logic                redirect,
    output logic                exc_taken,
    output exc_pkg::exc_code_t  exc_code,
    output logic [31:0]         target,
    input  logic                cp0_we,
    input  exc_pkg::cp0_reg_t   cp0_sel,
    input  logic [31:0]         cp0_wdata,
    output logic [31:0]         cp0_rdata
);

    import exc_pkg::*;

    logic        s1_valid;
    logic        s2_ready;
    logic        s1_exc_taken;
    logic        s1_eret;
    exc_code_t   s1_code;
    logic [31:0] s1_epc;
    logic        s1_in_bd;
    logic [31:0] s1_badvaddr;
    logic        s1_load_badvaddr;
    logic [31:0] s1_next_pc;
    logic [31:0] status;
    logic [1:0]  cause_ip_soft;

    exception_classifier exception_classifier_inst (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready),
        .pc (pc), .mem_addr (mem_addr), .mem_mode (mem_mode), .exc_chk (exc_chk),
        .cond_flag (cond_flag), .is_cop0 (is_cop0), .is_branch (is_branch),
        .hardware_int (hardware_int), .status (status), .cause_ip_soft (cause_ip_soft),
        .s2_ready (s2_ready), .s1_valid (s1_valid),
        .s1_exc_taken (s1_exc_taken), .s1_eret (s1_eret), .s1_code (s1_code),
        .s1_epc (s1_epc), .s1_in_bd (s1_in_bd), .s1_badvaddr (s1_badvaddr),
        .s1_load_badvaddr (s1_load_badvaddr), .s1_next_pc (s1_next_pc)
    );

    cop0_exc_regs cop0_exc_regs_inst (
        .clk (clk), .rst_n (rst_n),
        .s1_valid (s1_valid), .s2_ready (s2_ready),
        .s1_exc_taken (s1_exc_taken), .s1_eret (s1_eret), .s1_code (s1_code),
        .s1_epc (s1_epc), .s1_in_bd (s1_in_bd), .s1_badvaddr (s1_badvaddr),
        .s1_load_badvaddr (s1_load_badvaddr), .s1_next_pc (s1_next_pc),
        .out_ready (out_ready), .cp0_we (cp0_we), .cp0_sel (cp0_sel),
        .cp0_wdata (cp0_wdata), .status (status), .cause_ip_soft (cause_ip_soft),
        .cp0_rdata (cp0_rdata), .out_valid (out_valid), .redirect (redirect),
        .exc_taken (exc_taken), .exc_code (exc_code), .target (target)
    );

endmodule

/* verif/exception_unit_tb.sv */
`timescale 1ns/1ns
`include "exc_macros.svh"

module exception_unit_tb;

    import exc_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000; // Generous bound on the length of all tests.
    localparam logic [31:0] BOOT_GENERAL = `EXC_BOOT_BASE + `EXC_OFF_GENERAL;
    localparam logic [31:0] USER_STATUS = `STATUS_RESET | (32'd1 << `STATUS_UM);
    localparam int IM_HW0 = `STATUS_IM_S + 2; // Mask bit of hardware_int[0].

    typedef struct packed {
        logic        redirect;
        logic        taken;
        exc_code_t   code;
        logic [31:0] target;
    } result_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] pc;
    logic [31:0] mem_addr;
    mem_mode_t   mem_mode;
    exc_chk_t    exc_chk;
    logic        cond_flag;
    logic        is_cop0;
    logic        is_branch;
    logic [5:0]  hardware_int;
    logic        out_valid;
    logic        out_ready;
    logic        redirect;
    logic        exc_taken;
    exc_code_t   exc_code;
    logic [31:0] target;
    logic        cp0_we;
    cp0_reg_t    cp0_sel;
    logic [31:0] cp0_wdata;
    logic [31:0] cp0_rdata;

    logic [15:0] lfsr_state;
    result_t     obs_q[$];
    int          cycle_count;

    exception_unit exception_unit_inst (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready),
        .pc (pc), .mem_addr (mem_addr), .mem_mode (mem_mode), .exc_chk (exc_chk),
        .cond_flag (cond_flag), .is_cop0 (is_cop0), .is_branch (is_branch),
        .hardware_int (hardware_int),
        .out_valid (out_valid), .out_ready (out_ready),
        .redirect (redirect), .exc_taken (exc_taken), .exc_code (exc_code), .target (target),
        .cp0_we (cp0_we), .cp0_sel (cp0_sel), .cp0_wdata (cp0_wdata), .cp0_rdata (cp0_rdata)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // A transfer seen here completes at the next rising edge.
    always @(negedge clk) begin
        #1;
        if (rst_n && out_valid && out_ready) begin
            obs_q.push_back('{redirect, exc_taken, exc_code, target});
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    // Taps 16, 14, 13, 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        repeat (n) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic check_code(input string name, input exc_code_t expected,
                              input exc_code_t actual);
        if (actual !== expected) begin
            $display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // Called on a falling edge; returns on the falling edge after the transfer.
    task automatic send_instr(input logic [31:0] ipc, input logic [31:0] addr,
                              input mem_mode_t mode, input exc_chk_t chk, input logic cond,
                              input logic cop0, input logic branch);
        in_valid  = 1'b1;
        pc        = ipc;
        mem_addr  = addr;
        mem_mode  = mode;
        exc_chk   = chk;
        cond_flag = cond;
        is_cop0   = cop0;
        is_branch = branch;
        #1;
        while (!in_ready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_plain(input logic [31:0] ipc);
        send_instr(ipc, 32'h0, MEM_NONE, CHK_NONE, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic expect_result(input logic exp_redirect, input logic exp_taken,
                                 input exc_code_t exp_code, input logic [31:0] exp_target);
        result_t res;
        while (obs_q.size() == 0) begin
            @(negedge clk);
        end
        res = obs_q.pop_front();
        check_bit("redirect", exp_redirect, res.redirect);
        check_bit("exc_taken", exp_taken, res.taken);
        if (exp_taken) begin
            check_code("exc_code", exp_code, res.code);
        end
        check_word("target", exp_target, res.target);
    endtask

    task automatic expect_pass(input logic [31:0] ipc);
        expect_result(1'b0, 1'b0, EXC_INT, ipc + 32'd4);
    endtask

    task automatic write_cp0(input cp0_reg_t sel, input logic [31:0] data);
        cp0_we    = 1'b1;
        cp0_sel   = sel;
        cp0_wdata = data;
        @(negedge clk);
        cp0_we = 1'b0;
    endtask

    task automatic read_cp0(input cp0_reg_t sel, output logic [31:0] data);
        cp0_sel = sel;
        #1;
        data = cp0_rdata;
        @(negedge clk);
    endtask

    task automatic test_reset_values;
        logic [31:0] rd;
        check_bit("in_ready", 1'b1, in_ready);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("redirect", 1'b0, redirect);
        read_cp0(CP0_STATUS, rd);
        check_word("status", `STATUS_RESET, rd);
        read_cp0(CP0_CAUSE, rd);
        check_word("cause", 32'h0, rd);
        read_cp0(CP0_EPC, rd);
        check_word("epc", 32'h0, rd);
        read_cp0(CP0_EBASE, rd);
        check_word("ebase", `EBASE_RESET, rd);
    endtask

    task automatic test_plain_stream;
        logic [31:0] pcs [16];
        logic [31:0] bits;
        bit          done;
        for (int i = 0; i < 16; i++) begin
            take_bits(30, bits);
            pcs[i] = {bits[29:0], 2'b00};
        end
        done = 1'b0;
        fork
            for (int i = 0; i < 16; i++) begin
                send_plain(pcs[i]);
            end
            begin
                for (int i = 0; i < 16; i++) begin
                    expect_pass(pcs[i]);
                end
                done = 1'b1;
            end
            begin
                while (!done) begin
                    take_bits(2, bits);
                    out_ready = |bits[1:0]; // Ready three cycles in four.
                    @(negedge clk);
                end
                out_ready = 1'b1;
            end
        join
        repeat (4) @(negedge clk);
        check_word("extra results", 32'd0, obs_q.size());
    endtask

    task automatic sync_user_case(input exc_chk_t chk, input logic cop0,
                                  input exc_code_t code, input logic [31:0] ipc);
        logic [31:0] rd;
        send_instr(ipc, 32'h0, MEM_NONE, chk, 1'b0, cop0, 1'b0);
        expect_result(1'b1, 1'b1, code, BOOT_GENERAL);
        read_cp0(CP0_EPC, rd);
        check_word("epc", ipc, rd);
        read_cp0(CP0_STATUS, rd);
        check_bit("status_exl", 1'b1, rd[`STATUS_EXL]);
        read_cp0(CP0_CAUSE, rd);
        check_code("cause_exc_code", code, exc_code_t'(rd[`CAUSE_EXC_S +: 5]));
        send_instr(32'h8000_0100, 32'h0, MEM_NONE, CHK_ERET, 1'b0, 1'b0, 1'b0);
        expect_result(1'b1, 1'b0, EXC_INT, ipc); // ERET returns to EPC.
        read_cp0(CP0_STATUS, rd);
        check_bit("status_exl", 1'b0, rd[`STATUS_EXL]);
    endtask

    task automatic test_sync_user;
        write_cp0(CP0_STATUS, USER_STATUS);
        sync_user_case(CHK_SYSCALL, 1'b0, EXC_SYS, 32'h0040_0000);
        sync_user_case(CHK_BREAK, 1'b0, EXC_BP, 32'h0040_0010);
        sync_user_case(CHK_RESERVED, 1'b0, EXC_RI, 32'h0040_0020);
        sync_user_case(CHK_NONE, 1'b1, EXC_CPU, 32'h0040_0030);
    endtask

    task automatic data_error_case(input mem_mode_t mode, input logic [31:0] addr,
                                   input exc_code_t code);
        logic [31:0] rd;
        send_instr(32'h0040_0100, addr, mode, CHK_NONE, 1'b0, 1'b0, 1'b0);
        expect_result(1'b1, 1'b1, code, BOOT_GENERAL);
        read_cp0(CP0_BADVADDR, rd);
        check_word("badvaddr", addr, rd);
    endtask

    task automatic test_address_errors;
        logic [31:0] rd;
        send_instr(32'h0040_0200, 32'h0000_1003, MEM_LOAD_BYTE, CHK_NONE, 1'b0, 1'b0, 1'b0);
        expect_pass(32'h0040_0200);
        send_instr(32'h0040_0204, 32'h0000_1001, MEM_STORE_BYTE, CHK_NONE, 1'b0, 1'b0, 1'b0);
        expect_pass(32'h0040_0204);
        data_error_case(MEM_LOAD_WORD, 32'h0000_1002, EXC_ADEL);
        data_error_case(MEM_LOAD_HALF, 32'h0000_1001, EXC_ADEL);
        data_error_case(MEM_STORE_WORD, 32'h0000_1003, EXC_ADES);
        data_error_case(MEM_STORE_HALF, 32'h0000_1005, EXC_ADES);
        send_plain(32'h0040_0102);
        expect_result(1'b1, 1'b1, EXC_ADEL, BOOT_GENERAL);
        read_cp0(CP0_BADVADDR, rd);
        check_word("badvaddr", 32'h0040_0102, rd);
    endtask

    task automatic test_delay_slot;
        logic [31:0] rd;
        write_cp0(CP0_STATUS, `STATUS_RESET);
        send_instr(32'h8000_0200, 32'h0, MEM_NONE, CHK_NONE, 1'b0, 1'b0, 1'b1);
        send_instr(32'h8000_0204, 32'h0, MEM_NONE, CHK_SYSCALL, 1'b0, 1'b0, 1'b0);
        expect_pass(32'h8000_0200);
        expect_result(1'b1, 1'b1, EXC_SYS, BOOT_GENERAL);
        read_cp0(CP0_EPC, rd);
        check_word("epc", 32'h8000_0200, rd); // The branch itself.
        read_cp0(CP0_CAUSE, rd);
        check_bit("cause_bd", 1'b1, rd[`CAUSE_BD]);
        write_cp0(CP0_STATUS, `STATUS_RESET);
        send_instr(32'h8000_0300, 32'h0, MEM_NONE, CHK_SYSCALL, 1'b0, 1'b0, 1'b0);
        expect_result(1'b1, 1'b1, EXC_SYS, BOOT_GENERAL);
        read_cp0(CP0_EPC, rd);
        check_word("epc", 32'h8000_0300, rd);
        read_cp0(CP0_CAUSE, rd);
        check_bit("cause_bd", 1'b0, rd[`CAUSE_BD]);
    endtask

    task automatic test_conditional;
        logic [31:0] rd;
        write_cp0(CP0_STATUS, `STATUS_RESET);
        send_instr(32'h8000_0400, 32'h0, MEM_NONE, CHK_OVERFLOW, 1'b0, 1'b0, 1'b0);
        expect_pass(32'h8000_0400);
        send_instr(32'h8000_0404, 32'h0, MEM_NONE, CHK_OVERFLOW, 1'b1, 1'b0, 1'b0);
        expect_result(1'b1, 1'b1, EXC_OV, BOOT_GENERAL);
        send_instr(32'h8000_0408, 32'h0, MEM_NONE, CHK_TRAP, 1'b0, 1'b0, 1'b0);
        expect_pass(32'h8000_0408);
        send_instr(32'h8000_040c, 32'h0, MEM_NONE, CHK_TRAP, 1'b1, 1'b0, 1'b0);
        expect_result(1'b1, 1'b1, EXC_TR, BOOT_GENERAL);
        send_instr(32'h8000_0410, 32'h0000_1002, MEM_LOAD_WORD, CHK_RESERVED,
                   1'b0, 1'b0, 1'b0);
        expect_result(1'b1, 1'b1, EXC_RI, BOOT_GENERAL);
        read_cp0(CP0_BADVADDR, rd);
        check_word("badvaddr", 32'h0040_0102, rd); // Untouched by RI.
    endtask

    task automatic test_interrupts;
        logic [31:0] rd;
        hardware_int = 6'b000001;
        write_cp0(CP0_STATUS, `STATUS_RESET | (32'd1 << `STATUS_IE));
        send_plain(32'h8000_0500);
        expect_pass(32'h8000_0500);
        write_cp0(CP0_STATUS, `STATUS_RESET | (32'd1 << IM_HW0));
        send_plain(32'h8000_0504);
        expect_pass(32'h8000_0504);
        write_cp0(CP0_STATUS, (32'd1 << `STATUS_IE) | (32'd1 << IM_HW0)); // BEV clear.
        send_plain(32'h8000_0508);
        expect_result(1'b1, 1'b1, EXC_INT, `EBASE_RESET + `EXC_OFF_GENERAL);
        read_cp0(CP0_EPC, rd);
        check_word("epc", 32'h8000_0508, rd);
        read_cp0(CP0_CAUSE, rd);
        check_code("cause_exc_code", EXC_INT, exc_code_t'(rd[`CAUSE_EXC_S +: 5]));
        send_plain(32'h8000_050c);
        expect_pass(32'h8000_050c);
        write_cp0(CP0_CAUSE, 32'd1 << `CAUSE_IV);
        write_cp0(CP0_STATUS, (32'd1 << `STATUS_IE) | (32'd1 << IM_HW0));
        send_plain(32'h8000_0510);
        expect_result(1'b1, 1'b1, EXC_INT, `EBASE_RESET + `EXC_OFF_INT);

        // Soft interrupt 0 through Cause IP.
        hardware_int = 6'b000000;
        write_cp0(CP0_CAUSE, (32'd1 << `CAUSE_IV) | (32'd1 << `CAUSE_IP_S));
        write_cp0(CP0_STATUS, 32'd1 << `STATUS_IE);
        send_plain(32'h8000_0600);
        expect_pass(32'h8000_0600);
        write_cp0(CP0_STATUS, (32'd1 << `STATUS_IE) | (32'd1 << `STATUS_IM_S));
        send_plain(32'h8000_0604);
        expect_result(1'b1, 1'b1, EXC_INT, `EBASE_RESET + `EXC_OFF_INT);
        send_plain(32'h8000_0608);
        expect_pass(32'h8000_0608);
        write_cp0(CP0_CAUSE, 32'h0);
    endtask

    initial begin
        lfsr_state   = 16'd90;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        pc           = '0;
        mem_addr     = '0;
        mem_mode     = MEM_NONE;
        exc_chk      = CHK_NONE;
        cond_flag    = 1'b0;
        is_cop0      = 1'b0;
        is_branch    = 1'b0;
        hardware_int = '0;
        out_ready    = 1'b1;
        cp0_we       = 1'b0;
        cp0_sel      = CP0_STATUS;
        cp0_wdata    = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_values();
        test_plain_stream();
        test_sync_user();
        test_address_errors();
        test_delay_slot();
        test_conditional();
        test_interrupts();
        $display("all tests passed");
        $finish;
    end

endmodule

/* project.f */
+incdir+hw
hw/exc_pkg.sv
hw/address_error_checker.sv
hw/exception_classifier.sv
hw/cop0_exc_regs.sv
hw/exception_unit.sv
verif/exception_unit_tb.sv
